// File: sources.f
+incdir+include
design/bits2prm_ctrl_pkg.sv
design/bits2prm_mem_pkg.sv
design/scratch_memory.sv
design/prm_width_rom.sv
design/bit_counter.sv
design/prm_accumulator.sv
design/bits2prm_fsm.sv
design/bits2prm_top.sv
tb/bits2prm_tb.sv

// File: tb/bits2prm_tb.sv
`default_nettype none

`include "bits2prm_consts.svh"

module bits2prm_tb
	import bits2prm_mem_pkg::*;
();

	localparam int DONE_TIMEOUT = 400;
	localparam int DRAIN_CYCLES = 30;

	logic clk;
	logic rst;
	logic start;
	logic done;
	logic test_mode;
	mem_wr_t test_wr;
	mem_rd_t test_rd;
	logic [`WORD_W-1:0] scratch_rdata;

	integer seed;
	int test_errors;
	int total_errors;
	int tests_run;
	int tests_failed;

	// Codec parameter widths in frame order
	int widths [0:`PRM_NO-1] = '{8, 10, 8, 1, 13, 4, 7, 5, 13, 4, 7};

	logic frame_bits [0:`SERIAL_SIZE-1];
	logic [`PRM_W-1:0] exp_prm [0:`PRM_NO-1];

	bits2prm_top bits2prm_top_inst (
		.clk(clk),
		.rst(rst),
		.start(start),
		.done(done),
		.test_mode(test_mode),
		.test_wr(test_wr),
		.test_rd(test_rd),
		.scratch_rdata(scratch_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Memory access through the test port
	//////////////////////////////////////////////////////////////////////

	task automatic write_word(input logic [`ADDR_W-1:0] addr, input logic [`WORD_W-1:0] data);
		@(negedge clk);
		test_wr.addr = addr;
		test_wr.data = data;
		test_wr.en = 1'b1;
		@(negedge clk);
		test_wr.en = 1'b0;
	endtask

	// Read data is registered, so take it one cycle later
	task automatic read_word(input logic [`ADDR_W-1:0] addr, output logic [`WORD_W-1:0] data);
		@(negedge clk);
		test_rd.addr = addr;
		@(negedge clk);
		data = scratch_rdata;
	endtask

	// Frame markers, plus junk in the parameter area so stale zeros show up
	task automatic load_frame();
		int i;
		for (i = 0; i < `SERIAL_SIZE; i++) begin
			write_word(`BITS_BASE + i, {16'h0000, frame_bits[i] ? `BIT_1 : `BIT_0});
		end
		for (i = 0; i < `PRM_NO; i++) begin
			write_word(`PRM_BASE + i, 32'hA5000000 | (`PRM_BASE + i));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Each parameter takes its bits MSB first, straight on in frame order
	task automatic ref_unpack();
		int pos;
		int k;
		int b;
		pos = 0;
		for (k = 0; k < `PRM_NO; k++) begin
			exp_prm[k] = '0;
			for (b = 0; b < widths[k]; b++) begin
				exp_prm[k] = {exp_prm[k][`PRM_W-2:0], frame_bits[pos]};
				pos++;
			end
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Frame run and result checks
	//////////////////////////////////////////////////////////////////////

	// restart_at gives the cycle of an extra start strobe, 0 for none
	task automatic run_frame(input string name, input int restart_at);
		int cycles;
		int pulses;
		int latency;
		int k;
		cycles = 0;
		pulses = 0;
		// Start to done covers INIT and DONE plus the cycles of every parameter
		latency = 2;
		for (k = 0; k < `PRM_NO; k++) begin
			latency += 2 + 2 * widths[k];
		end
		@(negedge clk);
		test_mode = 1'b0;
		start = 1'b1;
		while (pulses == 0 && cycles < DONE_TIMEOUT) begin
			@(negedge clk);
			cycles++;
			start = (restart_at != 0 && cycles == restart_at);
			if (done) begin
				pulses++;
			end
		end
		if (pulses == 0) begin
			$display("%s: no done pulse within %0d cycles", name, DONE_TIMEOUT);
			test_errors++;
		end else begin
			if (cycles != latency) begin
				$display("Fail %s: done cycle expected %0d, actual %0d",
					name, latency, cycles);
				test_errors++;
			end
			// Watch for a stray second pulse
			repeat (DRAIN_CYCLES) begin
				@(negedge clk);
				start = 1'b0;
				if (done) begin
					pulses++;
				end
			end
			if (pulses != 1) begin
				$display("Fail %s: done pulses expected 1, actual %0d", name, pulses);
				test_errors++;
			end
		end
		start = 1'b0;
		test_mode = 1'b1;
	endtask

	task automatic check_params(input string name);
		int k;
		logic [`WORD_W-1:0] got;
		logic [`WORD_W-1:0] want;
		for (k = 0; k < `PRM_NO; k++) begin
			read_word(`PRM_BASE + k, got);
			want = {{(`WORD_W-`PRM_W){1'b0}}, exp_prm[k]};
			if (got !== want) begin
				$display("Fail %s: prm %0d expected %h, actual %h", name, k, want, got);
				test_errors++;
			end
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		total_errors += test_errors;
		if (test_errors == 0) begin
			$display("Test %s passed", name);
		end else begin
			$display("Test %s failed with %0d errors", name, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic reset_quiet();
		repeat (10) begin
			@(negedge clk);
			if (done) begin
				$display("reset_quiet: done pulsed with no start");
				test_errors++;
			end
		end
		end_test("reset_quiet");
	endtask

	task automatic mem_port_loopback();
		int i;
		logic [`ADDR_W-1:0] addr;
		logic [`WORD_W-1:0] got;
		for (i = 0; i < 8; i++) begin
			addr = 12'h300 + i * 12'h011;
			write_word(addr, {addr, addr ^ 12'hFFF, 8'h3C});
		end
		for (i = 0; i < 8; i++) begin
			addr = 12'h300 + i * 12'h011;
			read_word(addr, got);
			if (got !== {addr, addr ^ 12'hFFF, 8'h3C}) begin
				$display("Fail mem_port_loopback: addr %h expected %h, actual %h",
					addr, {addr, addr ^ 12'hFFF, 8'h3C}, got);
				test_errors++;
			end
		end
		end_test("mem_port_loopback");
	endtask

	task automatic all_zero_frame();
		int i;
		for (i = 0; i < `SERIAL_SIZE; i++) begin
			frame_bits[i] = 1'b0;
		end
		for (i = 0; i < `PRM_NO; i++) begin
			exp_prm[i] = '0;
		end
		load_frame();
		run_frame("all_zero_frame", 0);
		check_params("all_zero_frame");
		end_test("all_zero_frame");
	endtask

	task automatic all_one_frame();
		int i;
		for (i = 0; i < `SERIAL_SIZE; i++) begin
			frame_bits[i] = 1'b1;
		end
		// Every bit set gives the largest value for each width
		for (i = 0; i < `PRM_NO; i++) begin
			exp_prm[i] = (`PRM_W'(1) << widths[i]) - `PRM_W'(1);
		end
		load_frame();
		run_frame("all_one_frame", 0);
		check_params("all_one_frame");
		end_test("all_one_frame");
	endtask

	task automatic random_frames();
		int f;
		int i;
		for (f = 0; f < 3; f++) begin
			for (i = 0; i < `SERIAL_SIZE; i++) begin
				frame_bits[i] = $random(seed) & 1;
			end
			ref_unpack();
			load_frame();
			run_frame("random_frames", 0);
			check_params("random_frames");
		end
		end_test("random_frames");
	endtask

	task automatic start_while_busy();
		int i;
		for (i = 0; i < `SERIAL_SIZE; i++) begin
			frame_bits[i] = $random(seed) & 1;
		end
		ref_unpack();
		load_frame();
		// Second strobe lands well inside the frame
		run_frame("start_while_busy", 60);
		check_params("start_while_busy");
		end_test("start_while_busy");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		seed = 32'h6187e193;
		test_errors = 0;
		total_errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rst = 1'b1;
		start = 1'b0;
		test_mode = 1'b1;
		test_wr = '0;
		test_rd = '0;
		repeat (5) @(negedge clk);
		rst = 1'b0;

		reset_quiet();
		mem_port_loopback();
		all_zero_frame();
		all_one_frame();
		random_frames();
		start_while_busy();

		$display("Tests run: %0d, tests failed: %0d, errors: %0d",
			tests_run, tests_failed, total_errors);
		if (total_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: design/bits2prm_top.sv
`default_nettype none

`include "bits2prm_consts.svh"

module bits2prm_top
	import bits2prm_ctrl_pkg::*;
	import bits2prm_mem_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic start,
	output logic done,
	input  wire logic test_mode,
	input  wire mem_wr_t test_wr,
	input  wire mem_rd_t test_rd,
	output logic [`WORD_W-1:0] scratch_rdata
);

	logic [3:0] rom_index;
	logic [3:0] width;
	logic cnt_clear;
	logic cnt_load;
	logic cnt_step;
	logic cnt_next_prm;
	logic [`ADDR_W-1:0] bit_addr;
	logic [3:0] prm_index;
	logic param_last;
	logic frame_last;
	acc_op_e acc_op;
	logic [`PRM_W-1:0] value;
	mem_wr_t fsm_wr;
	mem_rd_t fsm_rd;
	mem_wr_t mux_wr;
	mem_rd_t mux_rd;

	//////////////////////////////////////////////////////////////////////
	// Test port multiplexer
	//////////////////////////////////////////////////////////////////////

	// Outside world owns the memory in test mode
	assign mux_wr = test_mode ? test_wr : fsm_wr;
	assign mux_rd = test_mode ? test_rd : fsm_rd;

	scratch_memory scratch_memory_inst (
		.clk(clk),
		.wr(mux_wr),
		.rd(mux_rd),
		.rdata(scratch_rdata)
	);

	prm_width_rom prm_width_rom_inst (
		.clk(clk),
		.index(rom_index),
		.width(width)
	);

	bit_counter bit_counter_inst (
		.clk(clk),
		.rst(rst),
		.clear(cnt_clear),
		.load(cnt_load),
		.width(width),
		.step(cnt_step),
		.next_prm(cnt_next_prm),
		.bit_addr(bit_addr),
		.prm_index(prm_index),
		.param_last(param_last),
		.frame_last(frame_last)
	);

	// Bit words come straight off the memory read port
	prm_accumulator prm_accumulator_inst (
		.clk(clk),
		.rst(rst),
		.op(acc_op),
		.bit_word(scratch_rdata),
		.value(value)
	);

	bits2prm_fsm bits2prm_fsm_inst (
		.clk(clk),
		.rst(rst),
		.start(start),
		.width(width),
		.param_last(param_last),
		.frame_last(frame_last),
		.prm_index(prm_index),
		.bit_addr(bit_addr),
		.value(value),
		.rom_index(rom_index),
		.cnt_clear(cnt_clear),
		.cnt_load(cnt_load),
		.cnt_step(cnt_step),
		.cnt_next_prm(cnt_next_prm),
		.acc_op(acc_op),
		.mem_rd(fsm_rd),
		.mem_wr(fsm_wr),
		.done(done)
	);

endmodule

`default_nettype wire

// File: design/bits2prm_fsm.sv
`default_nettype none

`include "bits2prm_consts.svh"

module bits2prm_fsm
	import bits2prm_ctrl_pkg::*;
	import bits2prm_mem_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic start,
	input  wire logic [3:0] width,
	input  wire logic param_last,
	input  wire logic frame_last,
	input  wire logic [3:0] prm_index,
	input  wire logic [`ADDR_W-1:0] bit_addr,
	input  wire logic [`PRM_W-1:0] value,
	output logic [3:0] rom_index,
	output logic cnt_clear,
	output logic cnt_load,
	output logic cnt_step,
	output logic cnt_next_prm,
	output acc_op_e acc_op,
	output mem_rd_t mem_rd,
	output mem_wr_t mem_wr,
	output logic done
);

	b2p_state_e state;
	b2p_state_e state_next;

	//////////////////////////////////////////////////////////////////////
	// State register and transitions
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (start) begin
					state_next = INIT;
				end
			end
			INIT: state_next = LOAD_W;
			LOAD_W: state_next = READ;
			READ: state_next = ACCUM;
			ACCUM: state_next = param_last ? WRITE : READ;
			WRITE: state_next = frame_last ? DONE : LOAD_W;
			DONE: state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Width ROM index
	//////////////////////////////////////////////////////////////////////

	// ROM is one cycle late, so look ahead while writing
	always_comb begin
		case (state)
			LOAD_W, READ, ACCUM: rom_index = prm_index;
			WRITE: rom_index = frame_last ? 4'd0 : prm_index + 4'd1;
			default: rom_index = 4'd0;
		endcase
	end

	// Counter and accumulator strobes
	assign cnt_clear = (state == INIT);
	assign cnt_load = (state == LOAD_W) && (width != 4'd0);
	assign cnt_step = (state == ACCUM);
	assign cnt_next_prm = (state == WRITE);

	always_comb begin
		case (state)
			LOAD_W: acc_op = ACC_CLEAR;
			ACCUM: acc_op = ACC_SHIFT;
			default: acc_op = ACC_HOLD;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Memory requests
	//////////////////////////////////////////////////////////////////////

	// Bit word address is held through ACCUM
	assign mem_rd.addr = bit_addr;

	assign mem_wr.addr = `PRM_BASE + {{(`ADDR_W-4){1'b0}}, prm_index};
	assign mem_wr.data = {{(`WORD_W-`PRM_W){1'b0}}, value};
	assign mem_wr.en = (state == WRITE);

	assign done = (state == DONE);

	// One done pulse, and only once every bit word has been consumed
	done_single: assert property (
		@(posedge clk) disable iff (rst)
		done |-> (bit_addr == `BITS_BASE + 12'(`SERIAL_SIZE)) ##1 !done
	) else $error("done pulse malformed or frame not fully consumed");

endmodule

`default_nettype wire

// File: design/prm_accumulator.sv
`default_nettype none

`include "bits2prm_consts.svh"

module prm_accumulator
	import bits2prm_ctrl_pkg::*;
(
	input  wire logic clk,
	input  wire logic rst,
	input  wire acc_op_e op,
	input  wire logic [`WORD_W-1:0] bit_word,
	output logic [`PRM_W-1:0] value
);

	logic is_one;

	// Marker lives in the low half of the word
	assign is_one = (bit_word[15:0] == `BIT_1);

	//////////////////////////////////////////////////////////////////////
	// Shift and add
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			value <= '0;
		end else begin
			case (op)
				ACC_CLEAR: value <= '0;
				ACC_SHIFT: begin
					// MSB first, so older bits move up
					value <= {value[`PRM_W-2:0], 1'b0} + {{(`PRM_W-1){1'b0}}, is_one};
				end
				default: value <= value;
			endcase
		end
	end

	// A corrupt bit word would otherwise be unpacked as a zero
	marker_valid: assert property (
		@(posedge clk) disable iff (rst)
		op == ACC_SHIFT |-> (bit_word[15:0] == `BIT_1 || bit_word[15:0] == `BIT_0)
	) else $error("bit word %h is not a marker", bit_word);

endmodule

`default_nettype wire

// File: design/bit_counter.sv
`default_nettype none

`include "bits2prm_consts.svh"

module bit_counter (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic clear,
	input  wire logic load,
	input  wire logic [3:0] width,
	input  wire logic step,
	input  wire logic next_prm,
	output logic [`ADDR_W-1:0] bit_addr,
	output logic [3:0] prm_index,
	output logic param_last,
	output logic frame_last
);

	logic [3:0] bits_left;

	always_ff @(posedge clk) begin
		if (rst) begin
			bit_addr <= `BITS_BASE;
			prm_index <= 4'd0;
			bits_left <= 4'd0;
		end else begin
			// Start of frame
			if (clear) begin
				bit_addr <= `BITS_BASE;
				prm_index <= 4'd0;
			end else begin
				if (step) begin
					bit_addr <= bit_addr + 12'd1;
				end
				if (next_prm) begin
					prm_index <= prm_index + 4'd1;
				end
			end
			if (load) begin
				bits_left <= width;
			end else if (step) begin
				bits_left <= bits_left - 4'd1;
			end
		end
	end

	// Step in progress consumes the final bit of this parameter
	assign param_last = (bits_left == 4'd1);
	assign frame_last = (prm_index == 4'(`PRM_NO - 1));

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	step_with_bits: assert property (
		@(posedge clk) disable iff (rst) step |-> bits_left != 4'd0
	) else $error("bit step with no bits left");

	addr_in_frame: assert property (
		@(posedge clk) disable iff (rst)
		step |-> bit_addr <= `BITS_BASE + 12'(`SERIAL_SIZE - 1)
	) else $error("bit address %0h past end of frame", bit_addr);

endmodule

`default_nettype wire

// File: design/prm_width_rom.sv
`default_nettype none

`include "bits2prm_consts.svh"

module prm_width_rom (
	input  wire logic clk,
	input  wire logic [3:0] index,
	output logic [3:0] width
);

	// Bit width of each codec parameter in frame order
	always_ff @(posedge clk) begin
		case (index)
			4'd0: width <= 4'd8;
			4'd1: width <= 4'd10;
			4'd2: width <= 4'd8;
			4'd3: width <= 4'd1;
			4'd4: width <= 4'd13;
			4'd5: width <= 4'd4;
			4'd6: width <= 4'd7;
			4'd7: width <= 4'd5;
			4'd8: width <= 4'd13;
			4'd9: width <= 4'd4;
			4'd10: width <= 4'd7;
			default: width <= 4'd0;
		endcase
	end

	// Sequencer must never look past the last parameter
	index_in_range: assert property (
		@(posedge clk) index < 4'(`PRM_NO)
	) else $error("width ROM index %0d out of range", index);

endmodule

`default_nettype wire

// File: design/scratch_memory.sv
`default_nettype none

`include "bits2prm_consts.svh"

module scratch_memory
	import bits2prm_mem_pkg::*;
(
	input  wire logic clk,
	input  wire mem_wr_t wr,
	input  wire mem_rd_t rd,
	output logic [`WORD_W-1:0] rdata
);

	localparam int DEPTH = 1 << `ADDR_W;

	logic [`WORD_W-1:0] mem [0:DEPTH-1];

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.addr] <= wr.data;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////////////////////////

	// Registered output, old data on a same-address write
	always_ff @(posedge clk) begin
		rdata <= mem[rd.addr];
	end

endmodule

`default_nettype wire

// File: design/bits2prm_mem_pkg.sv
`default_nettype none

`include "bits2prm_consts.svh"

package bits2prm_mem_pkg;

	// Write request to the scratch memory
	typedef struct packed {
		logic [`ADDR_W-1:0] addr;
		logic [`WORD_W-1:0] data;
		logic en;
	} mem_wr_t;

	// Read request, data follows one cycle later
	typedef struct packed {
		logic [`ADDR_W-1:0] addr;
	} mem_rd_t;

endpackage

`default_nettype wire

// File: design/bits2prm_ctrl_pkg.sv
`default_nettype none

package bits2prm_ctrl_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sequencer states
	//////////////////////////////////////////////////////////////////////

	// One pass per frame, LOAD_W to WRITE repeats per parameter
	typedef enum logic [2:0] {
		IDLE,
		INIT,
		LOAD_W,
		READ,
		ACCUM,
		WRITE,
		DONE
	} b2p_state_e;

	//////////////////////////////////////////////////////////////////////
	// Accumulator opcodes
	//////////////////////////////////////////////////////////////////////

	// Shift doubles the value and adds the incoming bit
	typedef enum logic [1:0] {
		ACC_HOLD,
		ACC_CLEAR,
		ACC_SHIFT
	} acc_op_e;

endpackage

`default_nettype wire

// File: include/bits2prm_consts.svh
`ifndef BITS2PRM_CONSTS_SVH
`define BITS2PRM_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Scratch memory geometry
//////////////////////////////////////////////////////////////////////

// Data word and address widths
`define WORD_W 32
`define ADDR_W 12

// Frame bit words start here, one marker per word
`define BITS_BASE 12'h100

// Unpacked parameters are written back here, one per word
`define PRM_BASE 12'h200

//////////////////////////////////////////////////////////////////////
// Frame format
//////////////////////////////////////////////////////////////////////

// Bit words in one received frame
`define SERIAL_SIZE 80

// Codec parameters per frame
`define PRM_NO 11

// Width of one unpacked parameter value
`define PRM_W 16

// Marker words for a received one and zero
`define BIT_1 16'h0081
`define BIT_0 16'h007F

`endif
